//--- hw/rs_config.svh
// size defines for the reservation station, physical tags, CDB and datapath
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// number of station slots
`define RS_DEPTH 8

// physical register file size, tag width follows from it
`define PHYS_REGS 32
`define TAG_W $clog2(`PHYS_REGS)

// broadcast ports on the common data bus
`define CDB_WIDTH 2

// data and immediate width
`define XLEN 32

// reorder buffer index width
`define ROB_W 4

`endif

//--- hw/rs_dispatch.sv
// dispatch stage: physical register busy table and station entry build
`timescale 1ns/10ps
`default_nettype none
`include "rs_config.svh"

module rs_dispatch
    import rs_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   disp_valid_i,
    input  disp_packet_t           disp_packet_i,
    output logic                   disp_ready_o,
    input  logic [`CDB_WIDTH-1:0]  cdb_valid_i,
    input  tag_t [`CDB_WIDTH-1:0]  cdb_tag_i,
    input  logic                   station_full_i,
    input  logic                   br_mispredict_i,
    output logic                   alloc_valid_o,
    output rs_entry_t              alloc_entry_o
);

    // one bit per physical register, set means value still in flight
    logic [`PHYS_REGS-1:0] busy_q;
    logic [`PHYS_REGS-1:0] busy_d;
    logic                  accept;

    // source ready check with same-cycle CDB bypass
    function automatic logic tag_ready(input tag_t tag);
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < `CDB_WIDTH; p++) begin
            hit |= cdb_valid_i[p] && (cdb_tag_i[p] == tag);
        end
        // tag 0 is the zero register
        return (tag == '0) || !busy_q[tag] || hit;
    endfunction

    // ====================================================================
    // handshake
    // ====================================================================
    // no dispatch while full or while a mispredict is applied
    assign disp_ready_o  = !station_full_i && !br_mispredict_i;
    assign accept        = disp_valid_i && disp_ready_o;
    assign alloc_valid_o = accept;

    // ====================================================================
    // busy table
    // ====================================================================
    always_comb begin
        busy_d = busy_q;
        // results on the CDB free their tags
        for (int p = 0; p < `CDB_WIDTH; p++) begin
            if (cdb_valid_i[p]) begin
                busy_d[cdb_tag_i[p]] = 1'b0;
            end
        end
        // new producer marks its destination
        if (accept && disp_packet_i.has_dest) begin
            busy_d[disp_packet_i.dest_tag] = 1'b1;
        end
        busy_d[0] = 1'b0;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    // ====================================================================
    // entry build
    // ====================================================================
    always_comb begin
        alloc_entry_o            = '0;
        alloc_entry_o.pkt        = disp_packet_i;
        alloc_entry_o.src1_ready = tag_ready(disp_packet_i.src1_tag);
        alloc_entry_o.src2_ready = tag_ready(disp_packet_i.src2_tag);
        alloc_entry_o.valid      = 1'b1;
        // branch tag is filled in by the slot on write
        alloc_entry_o.br_tag     = 1'b0;
    end

endmodule

`default_nettype wire

//--- hw/rs_entry.sv
// single reservation station slot with operand wakeup and branch tag
`timescale 1ns/10ps
`default_nettype none
`include "rs_config.svh"

module rs_entry
    import rs_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   write_i,
    input  rs_entry_t              entry_i,
    input  logic                   issue_i,
    input  logic [`CDB_WIDTH-1:0]  cdb_valid_i,
    input  tag_t [`CDB_WIDTH-1:0]  cdb_tag_i,
    input  logic                   spec_i,
    input  logic                   clear_tag_i,
    input  logic                   squash_i,
    output rs_entry_t              entry_o,
    output logic                   empty_o,
    output logic                   ready_o
);

    // payload
    disp_packet_t pkt_q;

    // control state
    logic valid_q;
    logic tag_q;
    logic rdy1_q;
    logic rdy2_q;

    // wakeup matches
    logic hit1;
    logic hit2;

    always_comb begin
        hit1 = 1'b0;
        hit2 = 1'b0;
        for (int p = 0; p < `CDB_WIDTH; p++) begin
            hit1 |= cdb_valid_i[p] && (cdb_tag_i[p] == pkt_q.src1_tag);
            hit2 |= cdb_valid_i[p] && (cdb_tag_i[p] == pkt_q.src2_tag);
        end
    end

    always_ff @(posedge clock) begin
        if (write_i) begin
            pkt_q <= entry_i.pkt;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
            tag_q   <= 1'b0;
            rdy1_q  <= 1'b0;
            rdy2_q  <= 1'b0;
        end else if (write_i) begin
            valid_q <= entry_i.valid;
            // speculative if dispatched behind an open branch
            tag_q   <= spec_i;
            rdy1_q  <= entry_i.src1_ready;
            rdy2_q  <= entry_i.src2_ready;
        end else begin
            // leave on grant, or on mispredict when younger than the branch
            if (issue_i || (squash_i && tag_q)) begin
                valid_q <= 1'b0;
            end
            if (clear_tag_i) begin
                tag_q <= 1'b0;
            end
            if (hit1) begin
                rdy1_q <= 1'b1;
            end
            if (hit2) begin
                rdy2_q <= 1'b1;
            end
        end
    end

    assign entry_o = '{pkt: pkt_q, src1_ready: rdy1_q, src2_ready: rdy2_q,
                       valid: valid_q, br_tag: tag_q};
    assign empty_o = !valid_q;
    // a slot being squashed is not offered for issue
    assign ready_o = valid_q && rdy1_q && rdy2_q && !(squash_i && tag_q);

endmodule

`default_nettype wire

//--- hw/rs_issue_select.sv
// issue select: ready entry picker, immediate decode, stall-holding output register
`timescale 1ns/10ps
`default_nettype none
`include "rs_config.svh"

module rs_issue_select
    import rs_pkg::*;
(
    input  logic                          clock,
    input  logic                          reset,
    input  rs_entry_t [`RS_DEPTH-1:0]     entries_i,
    input  logic [`RS_DEPTH-1:0]          entry_ready_i,
    input  logic                          issue_stall_i,
    output logic [`RS_DEPTH-1:0]          issue_grant_o,
    output logic                          issue_valid_o,
    output issue_packet_t                 issue_packet_o
);

    logic             can_load;
    rs_entry_t        pick;
    logic [`XLEN-1:0] imm;
    logic             valid_q;
    issue_packet_t    packet_q;

    // output register empty or drained this cycle
    assign can_load = !valid_q || !issue_stall_i;

    // lowest ready index, one grant per cycle
    always_comb begin
        issue_grant_o = '0;
        pick          = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (entry_ready_i[i]) begin
                issue_grant_o    = '0;
                issue_grant_o[i] = 1'b1;
                pick             = entries_i[i];
            end
        end
        if (!can_load) begin
            issue_grant_o = '0;
        end
    end

    // ====================================================================
    // immediate decode
    // ====================================================================
    always_comb begin
        if (pick.pkt.imm_kind == IMM_U) begin
            // upper immediate sits in bits 31:12
            imm = `XLEN'(signed'({pick.pkt.inst.u.imm, 12'b0}));
        end else begin
            imm = `XLEN'(signed'(pick.pkt.inst.i.imm));
        end
    end

    // ====================================================================
    // issue register
    // ====================================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (can_load) begin
            valid_q <= |issue_grant_o;
        end
    end

    always_ff @(posedge clock) begin
        if (|issue_grant_o) begin
            packet_q <= '{imm: imm, fu_type: pick.pkt.fu_type, rob_idx: pick.pkt.rob_idx,
                          dest_tag: pick.pkt.dest_tag, src1_tag: pick.pkt.src1_tag,
                          src2_tag: pick.pkt.src2_tag};
        end
    end

    assign issue_valid_o  = valid_q;
    assign issue_packet_o = packet_q;

endmodule

`default_nettype wire

//--- hw/rs_issue_top.sv
// issue subsystem top: dispatch, reservation station and issue select
`timescale 1ns/10ps
`default_nettype none
`include "rs_config.svh"

module rs_issue_top
    import rs_pkg::*;
(
    input  logic                          clock,
    input  logic                          reset,
    // rename side
    input  logic                          disp_valid_i,
    input  disp_packet_t                  disp_packet_i,
    output logic                          disp_ready_o,
    // common data bus
    input  logic [`CDB_WIDTH-1:0]         cdb_valid_i,
    input  tag_t [`CDB_WIDTH-1:0]         cdb_tag_i,
    // branch unit pulses
    input  logic                          br_mispredict_i,
    input  logic                          br_resolve_i,
    // execution side
    input  logic                          issue_stall_i,
    output logic                          issue_valid_o,
    output issue_packet_t                 issue_packet_o
);

    logic                       alloc_valid;
    rs_entry_t                  alloc_entry;
    logic                       station_full;
    rs_entry_t [`RS_DEPTH-1:0]  entries;
    logic [`RS_DEPTH-1:0]       entry_ready;
    logic [`RS_DEPTH-1:0]       issue_grant;

    // producer
    rs_dispatch rs_dispatch_inst (
        .clock           (clock),
        .reset           (reset),
        .disp_valid_i    (disp_valid_i),
        .disp_packet_i   (disp_packet_i),
        .disp_ready_o    (disp_ready_o),
        .cdb_valid_i     (cdb_valid_i),
        .cdb_tag_i       (cdb_tag_i),
        .station_full_i  (station_full),
        .br_mispredict_i (br_mispredict_i),
        .alloc_valid_o   (alloc_valid),
        .alloc_entry_o   (alloc_entry)
    );

    // buffer
    rs_station rs_station_inst (
        .clock           (clock),
        .reset           (reset),
        .alloc_valid_i   (alloc_valid),
        .alloc_entry_i   (alloc_entry),
        .cdb_valid_i     (cdb_valid_i),
        .cdb_tag_i       (cdb_tag_i),
        .br_mispredict_i (br_mispredict_i),
        .br_resolve_i    (br_resolve_i),
        .issue_grant_i   (issue_grant),
        .station_full_o  (station_full),
        .entries_o       (entries),
        .entry_ready_o   (entry_ready)
    );

    // consumer
    rs_issue_select rs_issue_select_inst (
        .clock          (clock),
        .reset          (reset),
        .entries_i      (entries),
        .entry_ready_i  (entry_ready),
        .issue_stall_i  (issue_stall_i),
        .issue_grant_o  (issue_grant),
        .issue_valid_o  (issue_valid_o),
        .issue_packet_o (issue_packet_o)
    );

endmodule

`default_nettype wire

//--- hw/rs_pkg.sv
// shared types: instruction union, dispatch/entry/issue structs and enums
`default_nettype none
`include "rs_config.svh"

package rs_pkg;

    // ====================================================================
    // basic types
    // ====================================================================
    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`ROB_W-1:0] rob_idx_t;

    // which immediate layout the word carries
    typedef enum logic [0:0] {
        IMM_I = 1'b0,
        IMM_U = 1'b1
    } imm_kind_e;

    // target functional unit class
    typedef enum logic [1:0] {
        FU_ALU    = 2'd0,
        FU_MUL    = 2'd1,
        FU_BRANCH = 2'd2,
        FU_MEM    = 2'd3
    } fu_type_e;

    // ====================================================================
    // instruction word, two views of the same 32 bits
    // ====================================================================
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        i_fmt_t i;
        u_fmt_t u;
    } inst_word_u;

    // ====================================================================
    // pipeline packets
    // ====================================================================
    // renamed instruction from rename
    typedef struct packed {
        inst_word_u inst;
        imm_kind_e  imm_kind;
        fu_type_e   fu_type;
        rob_idx_t   rob_idx;
        logic       has_dest;
        tag_t       dest_tag;
        tag_t       src1_tag;
        tag_t       src2_tag;
    } disp_packet_t;

    // one station slot
    typedef struct packed {
        disp_packet_t pkt;
        logic         src1_ready;
        logic         src2_ready;
        logic         valid;
        logic         br_tag;
    } rs_entry_t;

    // what leaves toward the execution side
    typedef struct packed {
        logic [`XLEN-1:0] imm;
        fu_type_e         fu_type;
        rob_idx_t         rob_idx;
        tag_t             dest_tag;
        tag_t             src1_tag;
        tag_t             src2_tag;
    } issue_packet_t;

endpackage

`default_nettype wire

//--- hw/rs_station.sv
// reservation station: slot array, free slot pick, full flag, branch tag control
`timescale 1ns/10ps
`default_nettype none
`include "rs_config.svh"

module rs_station
    import rs_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                alloc_valid_i,
    input  rs_entry_t                           alloc_entry_i,
    input  logic [`CDB_WIDTH-1:0]               cdb_valid_i,
    input  tag_t [`CDB_WIDTH-1:0]               cdb_tag_i,
    input  logic                                br_mispredict_i,
    input  logic                                br_resolve_i,
    input  logic [`RS_DEPTH-1:0]                issue_grant_i,
    output logic                                station_full_o,
    output rs_entry_t [`RS_DEPTH-1:0]           entries_o,
    output logic [`RS_DEPTH-1:0]                entry_ready_o
);

    logic [`RS_DEPTH-1:0] empty;
    logic [`RS_DEPTH-1:0] alloc_sel;
    logic [`RS_DEPTH-1:0] write;
    logic                 branch_in;
    logic                 spec_q;
    logic                 spec_write;
    logic                 clear_tag;

    // ====================================================================
    // free slot pick
    // ====================================================================
    // lowest empty index wins, scan runs high to low
    always_comb begin
        alloc_sel = '0;
        for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
            if (empty[i]) begin
                alloc_sel    = '0;
                alloc_sel[i] = 1'b1;
            end
        end
    end

    assign write          = alloc_valid_i ? alloc_sel : '0;
    assign station_full_o = ~|empty;

    // ====================================================================
    // speculation flag
    // ====================================================================
    // single open branch at a time
    assign branch_in = alloc_valid_i && (alloc_entry_i.pkt.fu_type == FU_BRANCH);
    assign clear_tag = br_resolve_i || br_mispredict_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            spec_q <= 1'b0;
        end else if (clear_tag) begin
            spec_q <= 1'b0;
        end else if (branch_in) begin
            spec_q <= 1'b1;
        end
    end

    // entries written in a resolve cycle are already safe
    assign spec_write = spec_q && !br_resolve_i;

    // ====================================================================
    // slot array
    // ====================================================================
    for (genvar i = 0; i < `RS_DEPTH; i++) begin : g_slot
        rs_entry rs_entry_inst (
            .clock       (clock),
            .reset       (reset),
            .write_i     (write[i]),
            .entry_i     (alloc_entry_i),
            .issue_i     (issue_grant_i[i]),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .spec_i      (spec_write),
            .clear_tag_i (clear_tag),
            .squash_i    (br_mispredict_i),
            .entry_o     (entries_o[i]),
            .empty_o     (empty[i]),
            .ready_o     (entry_ready_o[i])
        );
    end

endmodule

`default_nettype wire

//--- rs_issue_top.f
+incdir+hw
hw/rs_pkg.sv
hw/rs_dispatch.sv
hw/rs_entry.sv
hw/rs_station.sv
hw/rs_issue_select.sv
hw/rs_issue_top.sv
sim/rs_issue_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the issue subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
    -f rs_issue_top.f \
    --top-module rs_issue_tb \
    -Mdir "$BUILD_DIR"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/Vrs_issue_tb" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG_FILE"; then
    exit 0
fi
echo "pass line not found in $LOG_FILE"
exit 1

//--- sim/rs_issue_tb.sv
// directed testbench with clock, reset, watchdog and six test tasks for the issue subsystem
`timescale 1ns/10ps
`default_nettype none
`include "rs_config.svh"

module rs_issue_tb
    import rs_pkg::*;
();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 6;
    // longest test needs about 40 cycles
    localparam int TEST_BUDGET  = 64;
    localparam int WATCHDOG     = RESET_CYCLES + NUM_TESTS * TEST_BUDGET;

    logic                          clock;
    logic                          reset;
    logic                          disp_valid_i;
    disp_packet_t                  disp_packet_i;
    logic                          disp_ready_o;
    logic [`CDB_WIDTH-1:0]         cdb_valid_i;
    tag_t [`CDB_WIDTH-1:0]         cdb_tag_i;
    logic                          br_mispredict_i;
    logic                          br_resolve_i;
    logic                          issue_stall_i;
    logic                          issue_valid_o;
    issue_packet_t                 issue_packet_o;

    int            cycle;
    int            errors;
    int            checks;
    int            seed;
    // log of consumed issue packets
    int            rob_q[$];
    logic [31:0]   imm_q[$];
    int            cyc_q[$];
    issue_packet_t pkt_q[$];

    rs_issue_top rs_issue_top_inst (
        .clock           (clock),
        .reset           (reset),
        .disp_valid_i    (disp_valid_i),
        .disp_packet_i   (disp_packet_i),
        .disp_ready_o    (disp_ready_o),
        .cdb_valid_i     (cdb_valid_i),
        .cdb_tag_i       (cdb_tag_i),
        .br_mispredict_i (br_mispredict_i),
        .br_resolve_i    (br_resolve_i),
        .issue_stall_i   (issue_stall_i),
        .issue_valid_o   (issue_valid_o),
        .issue_packet_o  (issue_packet_o)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // edge counter read at the falling edge
    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // a packet shown at the falling edge without stall leaves at the next edge
    always @(negedge clock) begin
        if (!reset && issue_valid_o && !issue_stall_i) begin
            rob_q.push_back(int'(issue_packet_o.rob_idx));
            imm_q.push_back(issue_packet_o.imm);
            cyc_q.push_back(cycle);
            pkt_q.push_back(issue_packet_o);
        end
    end

    initial begin
        #(WATCHDOG * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", WATCHDOG);
        $display("CHECKS FAILED");
        $finish;
    end

    // ====================================================================
    // helpers
    // ====================================================================
    task automatic check_eq(input string test, input string what,
                            input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        assert (expected === actual) else begin
            errors++;
            $display("[FAIL] %s: %s expected %0h actual %0h", test, what, expected, actual);
        end
    endtask

    task automatic check_true(input string test, input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("error in %s: %s", test, what);
        end
    endtask

    // ISA immediate rules on the raw word
    function automatic logic [31:0] expected_imm(input logic [31:0] word,
                                                 input imm_kind_e kind);
        if (kind == IMM_U) begin
            return {word[31:12], 12'h000};
        end
        return {{20{word[31]}}, word[31:20]};
    endfunction

    function automatic disp_packet_t make_packet(input logic [31:0] word,
                                                 input imm_kind_e kind, input fu_type_e fu,
                                                 input int rob, input logic has_dest,
                                                 input int dest, input int src1, input int src2);
        disp_packet_t p;
        p.inst     = inst_word_u'(word);
        p.imm_kind = kind;
        p.fu_type  = fu;
        p.rob_idx  = rob_idx_t'(rob);
        p.has_dest = has_dest;
        p.dest_tag = tag_t'(dest);
        p.src1_tag = tag_t'(src1);
        p.src2_tag = tag_t'(src2);
        return p;
    endfunction

    function automatic logic [31:0] next_word();
        return $random(seed);
    endfunction

    task automatic clear_log();
        rob_q.delete();
        imm_q.delete();
        cyc_q.delete();
        pkt_q.delete();
    endtask

    // offer one instruction and return the edge that accepted it
    task automatic dispatch(input disp_packet_t pkt, output int accept_edge);
        int waited;
        waited = 0;
        @(posedge clock);
        #1;
        disp_valid_i  = 1'b1;
        disp_packet_i = pkt;
        @(negedge clock);
        while (!disp_ready_o && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        check_true("dispatch", disp_ready_o, "dispatch was never accepted");
        accept_edge = cycle + 1;
        @(posedge clock);
        #1;
        disp_valid_i = 1'b0;
    endtask

    // one-cycle CDB broadcast that returns its edge
    task automatic broadcast(input int port, input int tag, output int cdb_edge);
        @(posedge clock);
        #1;
        cdb_valid_i[port] = 1'b1;
        cdb_tag_i[port]   = tag_t'(tag);
        @(negedge clock);
        cdb_edge = cycle + 1;
        @(posedge clock);
        #1;
        cdb_valid_i = '0;
    endtask

    task automatic wait_issues(input string test, input int count);
        int waited;
        waited = 0;
        while (rob_q.size() < count && waited < 40) begin
            @(posedge clock);
            waited++;
        end
        check_true(test, rob_q.size() >= count, "timed out waiting for issued packets");
    endtask

    // ====================================================================
    // tests
    // ====================================================================
    task automatic test_reset_state();
        @(negedge clock);
        check_eq("reset_state", "issue_valid_o", 0, 32'(issue_valid_o));
        check_eq("reset_state", "disp_ready_o", 1, 32'(disp_ready_o));
    endtask

    task automatic test_ready_issue();
        logic [31:0] word_a;
        logic [31:0] word_b;
        int          edge_a;
        int          edge_b;
        word_a = next_word();
        word_b = next_word();
        clear_log();
        // sources 3 and 4 were never marked busy
        dispatch(make_packet(word_a, IMM_I, FU_ALU, 1, 1'b1, 6, 3, 4), edge_a);
        dispatch(make_packet(word_b, IMM_U, FU_MUL, 2, 1'b1, 7, 4, 3), edge_b);
        wait_issues("ready_issue", 2);
        if (rob_q.size() >= 2) begin
            check_eq("ready_issue", "first rob", 1, rob_q[0]);
            check_eq("ready_issue", "first edge", edge_a + 1, cyc_q[0]);
            check_eq("ready_issue", "I imm", expected_imm(word_a, IMM_I), imm_q[0]);
            check_eq("ready_issue", "first fu", 32'(FU_ALU), 32'(pkt_q[0].fu_type));
            check_eq("ready_issue", "first dest", 6, 32'(pkt_q[0].dest_tag));
            check_eq("ready_issue", "first src1", 3, 32'(pkt_q[0].src1_tag));
            check_eq("ready_issue", "first src2", 4, 32'(pkt_q[0].src2_tag));
            check_eq("ready_issue", "second rob", 2, rob_q[1]);
            check_eq("ready_issue", "second edge", edge_b + 1, cyc_q[1]);
            check_eq("ready_issue", "U imm", expected_imm(word_b, IMM_U), imm_q[1]);
            check_eq("ready_issue", "second fu", 32'(FU_MUL), 32'(pkt_q[1].fu_type));
            check_eq("ready_issue", "second dest", 7, 32'(pkt_q[1].dest_tag));
            check_eq("ready_issue", "second src1", 4, 32'(pkt_q[1].src1_tag));
            check_eq("ready_issue", "second src2", 3, 32'(pkt_q[1].src2_tag));
        end
    endtask

    task automatic test_wakeup();
        int edge_a;
        int edge_b;
        int cdb_edge;
        clear_log();
        // A produces tag 5 and B consumes it
        dispatch(make_packet(next_word(), IMM_I, FU_ALU, 13, 1'b1, 5, 0, 0), edge_a);
        dispatch(make_packet(next_word(), IMM_I, FU_ALU, 14, 1'b0, 0, 5, 0), edge_b);
        wait_issues("wakeup", 1);
        repeat (5) @(posedge clock);
        check_eq("wakeup", "packets before broadcast", 1, rob_q.size());
        broadcast(1, 5, cdb_edge);
        wait_issues("wakeup", 2);
        if (rob_q.size() >= 2) begin
            check_eq("wakeup", "rob after broadcast", 14, rob_q[1]);
            check_true("wakeup", cyc_q[1] >= cdb_edge + 1, "B issued before its wakeup");
        end
    endtask

    task automatic test_fill_priority();
        int edge_no;
        int cdb_edge;
        clear_log();
        dispatch(make_packet(next_word(), IMM_I, FU_ALU, 0, 1'b1, 9, 0, 0), edge_no);
        wait_issues("fill_priority", 1);
        for (int i = 1; i <= `RS_DEPTH; i++) begin
            dispatch(make_packet(next_word(), IMM_I, FU_ALU, i, 1'b0, 0, 9, 0), edge_no);
        end
        @(negedge clock);
        check_eq("fill_priority", "disp_ready_o when full", 0, 32'(disp_ready_o));
        broadcast(0, 9, cdb_edge);
        wait_issues("fill_priority", `RS_DEPTH + 1);
        if (rob_q.size() >= `RS_DEPTH + 1) begin
            check_eq("fill_priority", "first wake edge", cdb_edge + 1, cyc_q[1]);
            for (int i = 1; i <= `RS_DEPTH; i++) begin
                check_eq("fill_priority", "issue order", i, rob_q[i]);
            end
            // one per cycle back to back
            for (int i = 2; i <= `RS_DEPTH; i++) begin
                check_eq("fill_priority", "issue edge", cyc_q[i - 1] + 1, cyc_q[i]);
            end
        end
    endtask

    task automatic test_backpressure();
        issue_packet_t held;
        int            edge_no;
        int            cdb_edge;
        int            waited;
        clear_log();
        dispatch(make_packet(next_word(), IMM_U, FU_ALU, 3, 1'b1, 10, 0, 0), edge_no);
        wait_issues("backpressure", 1);
        clear_log();
        for (int i = 4; i <= 7; i++) begin
            dispatch(make_packet(next_word(), IMM_I, FU_MEM, i, 1'b0, 0, 0, 10), edge_no);
        end
        @(posedge clock);
        #1;
        issue_stall_i = 1'b1;
        broadcast(0, 10, cdb_edge);
        waited = 0;
        @(negedge clock);
        while (!issue_valid_o && waited < 10) begin
            @(negedge clock);
            waited++;
        end
        held = issue_packet_o;
        check_eq("backpressure", "held rob", 4, 32'(held.rob_idx));
        // the held packet must not move
        repeat (6) begin
            @(negedge clock);
            check_true("backpressure", issue_valid_o && issue_packet_o == held,
                       "issue packet changed while stalled");
        end
        check_eq("backpressure", "packets during stall", 0, rob_q.size());
        @(posedge clock);
        #1;
        issue_stall_i = 1'b0;
        wait_issues("backpressure", 4);
        if (rob_q.size() >= 4) begin
            for (int i = 0; i < 4; i++) begin
                check_eq("backpressure", "release order", i + 4, rob_q[i]);
            end
        end
    endtask

    task automatic test_mispredict();
        int edge_no;
        int cdb_edge;
        clear_log();
        dispatch(make_packet(next_word(), IMM_I, FU_ALU, 8, 1'b1, 12, 0, 0), edge_no);
        // older, branch, then two younger behind it
        dispatch(make_packet(next_word(), IMM_I, FU_ALU, 9, 1'b0, 0, 12, 0), edge_no);
        dispatch(make_packet(next_word(), IMM_I, FU_BRANCH, 10, 1'b0, 0, 0, 0), edge_no);
        dispatch(make_packet(next_word(), IMM_I, FU_ALU, 11, 1'b0, 0, 12, 0), edge_no);
        dispatch(make_packet(next_word(), IMM_U, FU_ALU, 12, 1'b0, 0, 0, 12), edge_no);
        wait_issues("mispredict", 2);
        @(posedge clock);
        #1;
        br_mispredict_i = 1'b1;
        @(negedge clock);
        check_eq("mispredict", "disp_ready_o in squash", 0, 32'(disp_ready_o));
        @(posedge clock);
        #1;
        br_mispredict_i = 1'b0;
        broadcast(1, 12, cdb_edge);
        repeat (10) @(posedge clock);
        check_eq("mispredict", "issued count", 3, rob_q.size());
        if (rob_q.size() >= 3) begin
            check_eq("mispredict", "producer rob", 8, rob_q[0]);
            check_eq("mispredict", "branch rob", 10, rob_q[1]);
            check_eq("mispredict", "older rob", 9, rob_q[2]);
        end
        foreach (rob_q[i]) begin
            check_true("mispredict", rob_q[i] != 11 && rob_q[i] != 12,
                       "a squashed instruction was issued");
        end
    endtask

    // ====================================================================
    // main sequence
    // ====================================================================
    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        disp_valid_i    = 1'b0;
        disp_packet_i   = '0;
        cdb_valid_i     = '0;
        cdb_tag_i       = '0;
        br_mispredict_i = 1'b0;
        br_resolve_i    = 1'b0;
        issue_stall_i   = 1'b0;
        cycle           = 0;
        errors          = 0;
        checks          = 0;
        seed            = 32'h5931_96f5;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        reset = 1'b0;

        test_reset_state();
        test_ready_issue();
        test_wakeup();
        test_fill_priority();
        test_backpressure();
        test_mispredict();

        $display("rs_issue_tb: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
